/* hw/alu_defs.svh */
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Datapath operand width
`define ALU_WIDTH 32

`define ALU_SHAMT_WIDTH 5

`define ALU_OPCODE_WIDTH 5

// Tag travels with each request to its response
`define ALU_TAG_WIDTH 4

`endif

/* hw/alu_pkg.sv */
`default_nettype none

`include "alu_defs.svh"

package alu_pkg;

	typedef enum logic [`ALU_OPCODE_WIDTH-1:0] {
		ALU_ADD = 5'd0,
		ALU_SUB = 5'd1,
		ALU_AND = 5'd2,
		ALU_OR  = 5'd3,
		ALU_SLL = 5'd4,
		ALU_SRA = 5'd5
	} alu_op_e;

	// Raw opcode, since illegal codes must pass through
	typedef struct packed {
		logic [`ALU_OPCODE_WIDTH-1:0] opcode;
		logic [`ALU_SHAMT_WIDTH-1:0]  shamt;
		logic [`ALU_WIDTH-1:0]        a;
		logic [`ALU_WIDTH-1:0]        b;
		logic [`ALU_TAG_WIDTH-1:0]    tag;
	} alu_req_t;

	// One bit per functional unit
	typedef struct packed {
		logic add;
		logic sub;
		logic and_op;
		logic or_op;
		logic sll;
		logic sra;
	} alu_sel_t;

	typedef struct packed {
		alu_sel_t                    sel;
		logic                        illegal;
		logic [`ALU_SHAMT_WIDTH-1:0] shamt;
		logic [`ALU_WIDTH-1:0]       a;
		logic [`ALU_WIDTH-1:0]       b;
		logic [`ALU_TAG_WIDTH-1:0]   tag;
	} alu_dec_t;

	// All unit results, selection happens in the last stage
	typedef struct packed {
		alu_sel_t                  sel;
		logic                      illegal;
		logic                      sign_a;
		logic                      sign_b;
		logic [`ALU_WIDTH-1:0]     sum;
		logic [`ALU_WIDTH-1:0]     diff;
		logic [`ALU_WIDTH-1:0]     and_res;
		logic [`ALU_WIDTH-1:0]     or_res;
		logic [`ALU_WIDTH-1:0]     sll_res;
		logic [`ALU_WIDTH-1:0]     sra_res;
		logic [`ALU_TAG_WIDTH-1:0] tag;
	} alu_exe_t;

	typedef struct packed {
		logic [`ALU_WIDTH-1:0]     result;
		logic                      not_equal;
		logic                      less_than;
		logic                      illegal;
		logic [`ALU_TAG_WIDTH-1:0] tag;
	} alu_resp_t;

endpackage

`default_nettype wire

/* hw/alu_decode.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_decode (
	input  alu_pkg::alu_req_t req,
	output alu_pkg::alu_dec_t dec
);

	localparam int NUM_CODES = 1 << `ALU_OPCODE_WIDTH;

	logic [NUM_CODES-1:0] onehot;

	// Shift a one into the opcode position
	assign onehot = NUM_CODES'(1) << req.opcode;

	always_comb begin
		dec.sel.add    = onehot[alu_pkg::ALU_ADD];
		dec.sel.sub    = onehot[alu_pkg::ALU_SUB];
		dec.sel.and_op = onehot[alu_pkg::ALU_AND];
		dec.sel.or_op  = onehot[alu_pkg::ALU_OR];
		dec.sel.sll    = onehot[alu_pkg::ALU_SLL];
		dec.sel.sra    = onehot[alu_pkg::ALU_SRA];

		// No defined unit hit
		dec.illegal = ~|dec.sel;

		dec.shamt = req.shamt;
		dec.a     = req.a;
		dec.b     = req.b;
		dec.tag   = req.tag;
	end

endmodule

`default_nettype wire

/* hw/carry_select_adder.sv */
`default_nettype none

`include "alu_defs.svh"

module carry_select_adder #(
	parameter int WIDTH = `ALU_WIDTH,
	parameter int BLOCK = 4
) (
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic             carry_in,
	output logic [WIDTH-1:0] sum,
	output logic             carry_out
);

	localparam int NUM_BLOCKS = WIDTH / BLOCK;

	logic [NUM_BLOCKS-1:0] carry;

	// Ripple adder over one block, carry out in the top bit
	function automatic logic [BLOCK:0] ripple(input logic [BLOCK-1:0] x,
			input logic [BLOCK-1:0] y, input logic cin);
		logic             c;
		logic [BLOCK-1:0] s;
		c = cin;
		for (int i = 0; i < BLOCK; i++) begin
			s[i] = x[i] ^ y[i] ^ c;
			c    = (x[i] & y[i]) | (c & (x[i] ^ y[i]));
		end
		return {c, s};
	endfunction

	assign {carry[0], sum[BLOCK-1:0]} = ripple(a[BLOCK-1:0], b[BLOCK-1:0], carry_in);

	for (genvar i = 1; i < NUM_BLOCKS; i++) begin : g_block
		logic [BLOCK:0] res0;
		logic [BLOCK:0] res1;

		// Both carry assumptions computed up front
		assign res0 = ripple(a[i*BLOCK +: BLOCK], b[i*BLOCK +: BLOCK], 1'b0);
		assign res1 = ripple(a[i*BLOCK +: BLOCK], b[i*BLOCK +: BLOCK], 1'b1);

		assign {carry[i], sum[i*BLOCK +: BLOCK]} = carry[i-1] ? res1 : res0;
	end

	assign carry_out = carry[NUM_BLOCKS-1];

endmodule

`default_nettype wire

/* hw/alu_execute.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_execute (
	input  alu_pkg::alu_dec_t dec,
	output alu_pkg::alu_exe_t exe
);

	logic [`ALU_WIDTH-1:0] sum;
	logic [`ALU_WIDTH-1:0] diff;

	carry_select_adder #(
		.WIDTH(`ALU_WIDTH)
	) u_add (
		.a        (dec.a),
		.b        (dec.b),
		.carry_in (1'b0),
		.sum      (sum),
		.carry_out()
	);

	// A + ~B + 1
	carry_select_adder #(
		.WIDTH(`ALU_WIDTH)
	) u_sub (
		.a        (dec.a),
		.b        (~dec.b),
		.carry_in (1'b1),
		.sum      (diff),
		.carry_out()
	);

	always_comb begin
		exe.sel     = dec.sel;
		exe.illegal = dec.illegal;
		exe.sign_a  = dec.a[`ALU_WIDTH-1];
		exe.sign_b  = dec.b[`ALU_WIDTH-1];
		exe.sum     = sum;
		exe.diff    = diff;
		exe.and_res = dec.a & dec.b;
		exe.or_res  = dec.a | dec.b;
		exe.sll_res = dec.a << dec.shamt;
		exe.sra_res = $signed(dec.a) >>> dec.shamt;
		exe.tag     = dec.tag;
	end

endmodule

`default_nettype wire

/* hw/alu_result.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_result (
	input  alu_pkg::alu_exe_t  exe,
	output alu_pkg::alu_resp_t resp
);

	logic diff_sign;

	assign diff_sign = exe.diff[`ALU_WIDTH-1];

	always_comb begin
		// AND-OR mux, an all-zero select gives zero
		resp.result = ({`ALU_WIDTH{exe.sel.add}}    & exe.sum)
			| ({`ALU_WIDTH{exe.sel.sub}}    & exe.diff)
			| ({`ALU_WIDTH{exe.sel.and_op}} & exe.and_res)
			| ({`ALU_WIDTH{exe.sel.or_op}}  & exe.or_res)
			| ({`ALU_WIDTH{exe.sel.sll}}    & exe.sll_res)
			| ({`ALU_WIDTH{exe.sel.sra}}    & exe.sra_res);

		resp.not_equal = |exe.diff;

		// Sign cases avoid overflow of the difference
		case ({exe.sign_a, exe.sign_b})
			2'b01:   resp.less_than = 1'b0;
			2'b10:   resp.less_than = 1'b1;
			default: resp.less_than = diff_sign;
		endcase

		resp.illegal = exe.illegal;
		resp.tag     = exe.tag;
	end

endmodule

`default_nettype wire

/* hw/pipe_stage.sv */
`default_nettype none

`include "alu_defs.svh"

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	// Empty or draining this cycle
	assign in_ready = ~out_valid | out_ready;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

endmodule

`default_nettype wire

/* hw/alu_pipe.sv */
`default_nettype none

`include "alu_defs.svh"

module alu_pipe (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               req_valid,
	output logic               req_ready,
	input  alu_pkg::alu_req_t  req,
	output logic               resp_valid,
	input  logic               resp_ready,
	output alu_pkg::alu_resp_t resp
);

	alu_pkg::alu_dec_t dec;
	alu_pkg::alu_dec_t dec_q;
	alu_pkg::alu_exe_t exe;
	alu_pkg::alu_exe_t exe_q;

	logic dec_valid;
	logic exe_ready;

	alu_decode u_decode (
		.req(req),
		.dec(dec)
	);

	// Decode to execute boundary
	pipe_stage #(
		.payload_t(alu_pkg::alu_dec_t)
	) s_dec (
		.clock    (clock),
		.rst_n    (rst_n),
		.in_valid (req_valid),
		.in_ready (req_ready),
		.in_data  (dec),
		.out_valid(dec_valid),
		.out_ready(exe_ready),
		.out_data (dec_q)
	);

	alu_execute u_execute (
		.dec(dec_q),
		.exe(exe)
	);

	// Execute to result boundary
	pipe_stage #(
		.payload_t(alu_pkg::alu_exe_t)
	) s_exe (
		.clock    (clock),
		.rst_n    (rst_n),
		.in_valid (dec_valid),
		.in_ready (exe_ready),
		.in_data  (exe),
		.out_valid(resp_valid),
		.out_ready(resp_ready),
		.out_data (exe_q)
	);

	alu_result u_result (
		.exe (exe_q),
		.resp(resp)
	);

endmodule

`default_nettype wire

/* tb/tb_alu_pipe.sv */
`default_nettype none

`include "alu_defs.svh"

module tb_alu_pipe;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD = 100;
	localparam int TOTAL_REQS = 219;
	localparam longint WATCHDOG_NS = (longint'(TOTAL_REQS) * 20 + 200) * PERIOD;

	logic               clock;
	logic               rst_n;
	logic               req_valid;
	logic               req_ready;
	alu_pkg::alu_req_t  req;
	logic               resp_valid;
	logic               resp_ready;
	alu_pkg::alu_resp_t resp;

	alu_pkg::alu_resp_t        exp_q[$];
	int unsigned               acc_q[$];
	int unsigned               cycle = 0;
	int unsigned               resp_count = 0;
	int                        pass_count = 0;
	int                        fail_count = 0;
	bit                        check_latency = 0;
	bit                        sends_done = 0;
	logic [`ALU_TAG_WIDTH-1:0] next_tag = '0;

	alu_pipe dut0 (
		.clock     (clock),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp      (resp)
	);

	initial clock = 1'b0;
	always #(PERIOD / 2) clock = ~clock;

	// Expected response straight from the opcode table and sign rule
	function automatic alu_pkg::alu_resp_t expect_resp(input alu_pkg::alu_req_t r);
		alu_pkg::alu_resp_t    e;
		logic [`ALU_WIDTH-1:0] d;
		e = '0;
		e.tag = r.tag;
		d = r.a - r.b;
		case (r.opcode)
			5'd0: e.result = r.a + r.b;
			5'd1: e.result = d;
			5'd2: e.result = r.a & r.b;
			5'd3: e.result = r.a | r.b;
			5'd4: e.result = r.a << r.shamt;
			5'd5: e.result = $signed(r.a) >>> r.shamt;
			default: e.illegal = 1'b1;
		endcase
		e.not_equal = (r.a != r.b);
		if (r.a[`ALU_WIDTH-1] != r.b[`ALU_WIDTH-1])
			e.less_than = r.a[`ALU_WIDTH-1];
		else
			e.less_than = d[`ALU_WIDTH-1];
		return e;
	endfunction

	function automatic alu_pkg::alu_req_t make_req(input logic [4:0] op, input logic [4:0] shamt,
			input logic [31:0] a, input logic [31:0] b);
		alu_pkg::alu_req_t r;
		r.opcode = op;
		r.shamt  = shamt;
		r.a      = a;
		r.b      = b;
		r.tag    = next_tag;
		next_tag = next_tag + 1;
		return r;
	endfunction

	task automatic check_field(input string name, input logic [31:0] expv, input logic [31:0] act);
		assert (expv === act) pass_count++;
		else begin
			fail_count++;
			$display("MISMATCH t=%0t %s expected %h actual %h", $time, name, expv, act);
		end
	endtask

	// Scoreboard on both handshakes
	always @(posedge clock) begin : monitor
		alu_pkg::alu_resp_t e;
		int unsigned        acc;
		cycle++;
		if (rst_n) begin
			if (resp_valid && resp_ready) begin
				resp_count++;
				if (exp_q.size() == 0) begin
					fail_count++;
					$display("ERROR t=%0t response with tag %h arrived with nothing outstanding",
						$time, resp.tag);
				end else begin
					e = exp_q.pop_front();
					acc = acc_q.pop_front();
					check_field("result", e.result, resp.result);
					check_field("not_equal", e.not_equal, resp.not_equal);
					check_field("less_than", e.less_than, resp.less_than);
					check_field("illegal", e.illegal, resp.illegal);
					check_field("tag", e.tag, resp.tag);
					if (check_latency)
						check_field("latency", 2, cycle - acc);
				end
			end
			if (req_valid && req_ready) begin
				exp_q.push_back(expect_resp(req));
				acc_q.push_back(cycle);
			end
		end
	end

	task automatic send_req(input alu_pkg::alu_req_t r);
		req = r;
		req_valid = 1'b1;
		do @(posedge clock); while (!req_ready);
		#10;
		req_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 200) begin
			@(posedge clock);
			#10;
			n++;
		end
		if (exp_q.size() != 0) begin
			fail_count++;
			$display("ERROR t=%0t %0d expected responses never arrived", $time, exp_q.size());
			exp_q.delete();
			acc_q.delete();
		end
	endtask

	task automatic reset_outputs();
		int f0;
		f0 = fail_count;
		// Downstream stalled, so req_ready depends on both stages being empty
		check_field("resp_valid", 0, resp_valid);
		check_field("req_ready", 1, req_ready);
		resp_ready = 1'b1;
		$display("test reset finished, %0d errors", fail_count - f0);
	endtask

	task automatic opcode_sweep();
		logic [31:0] ca[4] = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff};
		logic [31:0] cb[4] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000};
		int          f0;
		f0 = fail_count;
		for (int op = 0; op < 6; op++) begin
			for (int i = 0; i < 4; i++) begin
				send_req(make_req(op, 5'd0, ca[i], cb[i]));
				send_req(make_req(op, 5'd31, ca[i], cb[i]));
			end
			for (int i = 0; i < 20; i++)
				send_req(make_req(op, $urandom, $urandom, $urandom));
		end
		wait_drain();
		$display("test opcodes finished, %0d errors", fail_count - f0);
	endtask

	task automatic flag_cases();
		int f0;
		f0 = fail_count;
		send_req(make_req(5'd1, 5'd0, 32'd5, 32'd5));
		send_req(make_req(5'd1, 5'd0, 32'h80000000, 32'h80000000));
		send_req(make_req(5'd1, 5'd0, 32'd3, -32'sd2));
		send_req(make_req(5'd1, 5'd0, -32'sd2, 32'd3));
		send_req(make_req(5'd1, 5'd0, 32'd7, 32'd9));
		send_req(make_req(5'd1, 5'd0, -32'sd9, -32'sd7));
		// Difference overflows here
		send_req(make_req(5'd1, 5'd0, 32'h80000000, 32'd1));
		send_req(make_req(5'd1, 5'd0, 32'd1, 32'h80000000));
		wait_drain();
		$display("test flags finished, %0d errors", fail_count - f0);
	endtask

	task automatic illegal_codes();
		int f0;
		f0 = fail_count;
		send_req(make_req(5'd6, 5'd3, 32'h12345678, 32'h0f0f0f0f));
		send_req(make_req(5'd17, 5'd31, 32'hffffffff, 32'h1));
		send_req(make_req(5'd31, 5'd7, 32'hdeadbeef, 32'hdeadbeef));
		wait_drain();
		$display("test illegal finished, %0d errors", fail_count - f0);
	endtask

	task automatic backpressure_stream();
		int          f0;
		int unsigned r0;
		f0 = fail_count;
		r0 = resp_count;
		sends_done = 0;
		resp_ready = 1'b0;
		fork
			begin
				for (int i = 0; i < 30; i++)
					send_req(make_req($urandom % 8, $urandom, $urandom, $urandom));
				sends_done = 1;
			end
			begin
				repeat (6) @(posedge clock);
				#10;
				check_field("req_ready", 0, req_ready);
				while (!sends_done || exp_q.size() != 0) begin
					@(posedge clock);
					#10;
					resp_ready = $urandom % 2;
				end
				resp_ready = 1'b1;
			end
		join
		wait_drain();
		check_field("resp_count", 30, resp_count - r0);
		$display("test backpressure finished, %0d errors", fail_count - f0);
	endtask

	task automatic latency_back_to_back();
		int          f0;
		int unsigned c0;
		int unsigned r0;
		f0 = fail_count;
		r0 = resp_count;
		resp_ready = 1'b1;
		check_latency = 1;
		c0 = cycle;
		for (int i = 0; i < 10; i++)
			send_req(make_req($urandom % 6, $urandom, $urandom, $urandom));
		// One acceptance per cycle
		check_field("send_cycles", 10, cycle - c0);
		wait_drain();
		check_latency = 0;
		check_field("resp_count", 10, resp_count - r0);
		$display("test latency finished, %0d errors", fail_count - f0);
	endtask

	initial begin
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		resp_ready = 1'b0;
		void'($urandom(57313));
		repeat (3) @(posedge clock);
		#10;
		rst_n = 1'b1;

		reset_outputs();
		opcode_sweep();
		flag_cases();
		illegal_codes();
		backpressure_stream();
		latency_back_to_back();

		$display("checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR t=%0t watchdog expired before the tests ended", $time);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* alu_pipe.f */
+incdir+hw
hw/alu_pkg.sv
hw/alu_decode.sv
hw/carry_select_adder.sv
hw/alu_execute.sv
hw/alu_result.sv
hw/pipe_stage.sv
hw/alu_pipe.sv
tb/tb_alu_pipe.sv

/* Bender.yml */
package:
  name: alu_pipe

sources:
  - include_dirs:
      - hw
    files:
      - hw/alu_pkg.sv
      - hw/alu_decode.sv
      - hw/carry_select_adder.sv
      - hw/alu_execute.sv
      - hw/alu_result.sv
      - hw/pipe_stage.sv
      - hw/alu_pipe.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_alu_pipe.sv
